/* dram_ctrl_panel.f */
source/panel_pkg.sv
source/panel_if.sv
source/panel_sync.sv
source/panel_value_mux.sv
source/seven_seg_scan.sv
source/dram_ctrl_panel.sv
verif/dram_ctrl_panel_assert.sv
verif/dram_ctrl_panel_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dram_ctrl_panel.f \
    --top-module dram_ctrl_panel_tb -o dram_ctrl_panel_sim

out=$(./obj_dir/dram_ctrl_panel_sim)
echo "$out"

echo "$out" | grep -q "All tests passed"

/* verif/dram_ctrl_panel_tb.sv */
module dram_ctrl_panel_tb;
    import panel_pkg::*;

    logic                   clk_dram_ctrl = 1'b0;
    logic                   rst_dram_ctrl;
    pot_t                   pots [POT_COUNT];  // volume, pitch, delay_wet ... crush_pressure
    src_t                   srcs [SRC_COUNT];  // output, crush, distortion, filter, reverb, delay
    disp_sel_t              disp_sel;
    logic                   memrequest_complete;
    logic                   write_tlast;
    seg_t                   ss_c;
    logic [DIGIT_COUNT-1:0] ss_an;
    logic                   write_seen;
    int                     errors = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;

    // lit segments per hex digit, a in bit 0, before the active-low inversion
    logic [6:0] lit_segs [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    dram_ctrl_panel dram_ctrl_panel_i (
        .clk_dram_ctrl         (clk_dram_ctrl),
        .rst_dram_ctrl         (rst_dram_ctrl),
        .i_volume              (pots[0]),
        .i_pitch               (pots[1]),
        .i_delay_wet           (pots[2]),
        .i_delay_rate          (pots[3]),
        .i_delay_feedback      (pots[4]),
        .i_reverb_wet          (pots[5]),
        .i_reverb_size         (pots[6]),
        .i_reverb_feedback     (pots[7]),
        .i_filter_quality      (pots[8]),
        .i_filter_cutoff       (pots[9]),
        .i_distortion_drive    (pots[10]),
        .i_crush_pressure      (pots[11]),
        .i_output_src          (srcs[0]),
        .i_crush_src           (srcs[1]),
        .i_distortion_src      (srcs[2]),
        .i_filter_src          (srcs[3]),
        .i_reverb_src          (srcs[4]),
        .i_delay_src           (srcs[5]),
        .i_disp_sel            (disp_sel),
        .i_memrequest_complete (memrequest_complete),
        .i_write_tlast         (write_tlast),
        .o_ss_c                (ss_c),
        .o_ss_an               (ss_an),
        .o_write_seen          (write_seen)
    );

    always #4 clk_dram_ctrl = ~clk_dram_ctrl;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s got 0x%h, expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    // -1 when the pattern is no hex digit
    function automatic int seg_to_nibble(input seg_t seg);
        for (int k = 0; k < 16; k++) begin
            if (lit_segs[k] == ~seg) return k;
        end
        return -1;
    endfunction

    // watch two full scan windows and rebuild the shown word
    task automatic read_display(output logic [31:0] word);
        logic [DIGIT_COUNT-1:0] seen;
        int                     digit;
        int                     nib;
        seen = '0;
        word = '0;
        repeat (DIGIT_COUNT * SCAN_HOLD_CYCLES * 2) begin
            @(negedge clk_dram_ctrl);
            digit = -1;
            for (int k = 0; k < DIGIT_COUNT; k++) begin
                if (ss_an == ~(DIGIT_COUNT'(1) << k)) digit = k;
            end
            if (digit >= 0) begin
                nib = seg_to_nibble(ss_c);
                if (nib < 0) begin
                    $display("cathode pattern 0x%h on digit %0d is not a hex digit", ss_c, digit);
                    errors++;
                end else begin
                    word[digit*4 +: 4] = nib[3:0];
                    seen[digit] = 1'b1;
                end
            end
        end
        if (seen != '1) begin
            $display("some digits were never lit during the scan, seen mask 0x%h", seen);
            errors++;
        end
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        repeat (15) @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        check_value("o_ss_an in reset", 32'(ss_an), 32'hFF);
        check_value("o_ss_c in reset", 32'(ss_c), 32'h7F);
        check_value("o_write_seen in reset", 32'(write_seen), 32'h0);
        @(posedge clk_dram_ctrl);
        rst_dram_ctrl <= 1'b0;
        @(negedge clk_dram_ctrl);
        check_value("o_ss_an after reset", 32'(ss_an), 32'hFF);
        check_value("o_ss_c after reset", 32'(ss_c), 32'h7F);
        check_value("o_write_seen after reset", 32'(write_seen), 32'h0);
        end_test("reset", err0);
    endtask

    task automatic test_req_counter();
        int          err0;
        int          target;
        int          pulses;
        logic [31:0] word;
        err0 = errors;
        target = $urandom_range(1, 300);
        pulses = 0;
        @(posedge clk_dram_ctrl);
        disp_sel <= 3'd0;
        while (pulses < target) begin
            @(posedge clk_dram_ctrl);
            if ($urandom_range(0, 3) != 0) begin // mostly back to back
                memrequest_complete <= 1'b1;
                pulses++;
            end else begin
                memrequest_complete <= 1'b0;
            end
        end
        @(posedge clk_dram_ctrl);
        memrequest_complete <= 1'b0;
        repeat (3) @(posedge clk_dram_ctrl);
        read_display(word);
        check_value("request count word", word, {16'h0, target[15:0]});
        end_test("request counter", err0);
    endtask

    task automatic test_setting_pairs();
        int          err0;
        int          hi;
        logic [31:0] word;
        logic [31:0] expected;
        err0 = errors;
        for (int s = 1; s <= 6; s++) begin
            @(posedge clk_dram_ctrl);
            for (int k = 0; k < POT_COUNT; k++) begin
                pots[k] <= pot_t'($urandom());
            end
            disp_sel <= disp_sel_t'(s);
            repeat (4) @(posedge clk_dram_ctrl); // two sync stages plus margin
            hi = 2 * (s - 1);
            expected = {6'h0, pots[hi], 6'h0, pots[hi + 1]};
            read_display(word);
            check_value($sformatf("pair word for select %0d", s), word, expected);
        end
        end_test("setting pairs", err0);
    endtask

    task automatic test_sources();
        int          err0;
        logic [31:0] word;
        logic [31:0] expected;
        err0 = errors;
        expected = '0;
        @(posedge clk_dram_ctrl);
        for (int k = 0; k < SRC_COUNT; k++) begin
            srcs[k] <= src_t'($urandom());
        end
        disp_sel <= 3'd7;
        repeat (4) @(posedge clk_dram_ctrl);
        for (int k = 0; k < SRC_COUNT; k++) begin
            expected[k*4 +: 4] = {1'b0, srcs[k]};
        end
        read_display(word);
        check_value("source word", word, expected);
        end_test("patch sources", err0);
    endtask

    task automatic test_write_seen();
        int err0;
        err0 = errors;
        repeat (10) begin
            @(negedge clk_dram_ctrl);
            check_value("o_write_seen before strobe", 32'(write_seen), 32'h0);
        end
        @(posedge clk_dram_ctrl);
        write_tlast <= 1'b1;
        @(negedge clk_dram_ctrl);
        check_value("o_write_seen during strobe", 32'(write_seen), 32'h0);
        @(posedge clk_dram_ctrl);
        write_tlast <= 1'b0;
        @(negedge clk_dram_ctrl);
        check_value("o_write_seen after strobe", 32'(write_seen), 32'h1);
        repeat (100) begin
            @(negedge clk_dram_ctrl);
            check_value("o_write_seen held", 32'(write_seen), 32'h1);
        end
        end_test("write seen", err0);
    endtask

    task automatic test_scan_order();
        int                     err0;
        int                     waited;
        logic [DIGIT_COUNT-1:0] prev;
        logic [DIGIT_COUNT-1:0] expected;
        err0 = errors;
        waited = 0;
        @(negedge clk_dram_ctrl);
        prev = ss_an;
        @(negedge clk_dram_ctrl);
        // first cycle of digit 0
        while (!(ss_an == 8'hFE && prev != 8'hFE) &&
               waited < 2 * DIGIT_COUNT * SCAN_HOLD_CYCLES) begin
            prev = ss_an;
            @(negedge clk_dram_ctrl);
            waited++;
        end
        if (waited >= 2 * DIGIT_COUNT * SCAN_HOLD_CYCLES) begin
            $display("the scan never came back to digit 0");
            errors++;
        end else begin
            for (int i = 0; i < DIGIT_COUNT * SCAN_HOLD_CYCLES; i++) begin
                expected = ~(DIGIT_COUNT'(1) << (i / SCAN_HOLD_CYCLES));
                check_value("o_ss_an in scan", 32'(ss_an), 32'(expected));
                @(negedge clk_dram_ctrl);
            end
            check_value("o_ss_an after wrap", 32'(ss_an), 32'hFE);
        end
        end_test("scan order", err0);
    endtask

    initial begin
        void'($urandom(74));
        rst_dram_ctrl = 1'b1;
        for (int k = 0; k < POT_COUNT; k++) begin
            pots[k] = '0;
        end
        for (int k = 0; k < SRC_COUNT; k++) begin
            srcs[k] = '0;
        end
        disp_sel = '0;
        memrequest_complete = 1'b0;
        write_tlast = 1'b0;
        test_reset();
        test_req_counter();
        test_setting_pairs();
        test_sources();
        test_write_seen();
        test_scan_order();
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        longint limit;
        limit = 20 * 6 * DIGIT_COUNT * SCAN_HOLD_CYCLES * 8; // six tests
        #(limit);
        $display("watchdog: the tests did not finish in the expected time");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* verif/dram_ctrl_panel_assert.sv */
module dram_ctrl_panel_assert (
    input logic                              clk_dram_ctrl,
    input logic                              rst_dram_ctrl,
    input logic [panel_pkg::DIGIT_COUNT-1:0] i_anode,
    input panel_pkg::seg_t                   i_seg,
    input logic                              i_write_seen
);
    import panel_pkg::*;

    // never two digits at once
    one_digit_lit: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        $countones(~i_anode) <= 1)
        else $error("more than one anode low, anodes 0x%h", i_anode);

    blank_when_dark: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (i_anode == ANODE_NONE) |-> (i_seg == SEG_BLANK))
        else $error("cathodes 0x%h driven with no digit lit", i_seg);

    // sticky until the next reset
    write_seen_holds: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        $past(i_write_seen) |-> i_write_seen)
        else $error("o_write_seen fell without a reset");

endmodule

bind dram_ctrl_panel dram_ctrl_panel_assert dram_ctrl_panel_assert_i (
    .clk_dram_ctrl (clk_dram_ctrl),
    .rst_dram_ctrl (rst_dram_ctrl),
    .i_anode       (o_ss_an),
    .i_seg         (o_ss_c),
    .i_write_seen  (o_write_seen)
);

/* source/dram_ctrl_panel.sv */
module dram_ctrl_panel (
    input  logic                              clk_dram_ctrl,
    input  logic                              rst_dram_ctrl,

    // settings from the panel domain
    input  panel_pkg::pot_t                   i_volume,
    input  panel_pkg::pot_t                   i_pitch,
    input  panel_pkg::pot_t                   i_delay_wet,
    input  panel_pkg::pot_t                   i_delay_rate,
    input  panel_pkg::pot_t                   i_delay_feedback,
    input  panel_pkg::pot_t                   i_reverb_wet,
    input  panel_pkg::pot_t                   i_reverb_size,
    input  panel_pkg::pot_t                   i_reverb_feedback,
    input  panel_pkg::pot_t                   i_filter_quality,
    input  panel_pkg::pot_t                   i_filter_cutoff,
    input  panel_pkg::pot_t                   i_distortion_drive,
    input  panel_pkg::pot_t                   i_crush_pressure,
    input  panel_pkg::src_t                   i_output_src,
    input  panel_pkg::src_t                   i_crush_src,
    input  panel_pkg::src_t                   i_distortion_src,
    input  panel_pkg::src_t                   i_filter_src,
    input  panel_pkg::src_t                   i_reverb_src,
    input  panel_pkg::src_t                   i_delay_src,

    input  panel_pkg::disp_sel_t              i_disp_sel,  // switch bank
    input  logic                              i_memrequest_complete,
    input  logic                              i_write_tlast,

    output panel_pkg::seg_t                   o_ss_c,
    output logic [panel_pkg::DIGIT_COUNT-1:0] o_ss_an,
    output logic                              o_write_seen
);
    import panel_pkg::*;

    disp_word_t disp_word;

    panel_if panel ();

    panel_sync panel_sync_i (
        .clk_dram_ctrl      (clk_dram_ctrl),
        .i_volume           (i_volume),
        .i_pitch            (i_pitch),
        .i_delay_wet        (i_delay_wet),
        .i_delay_rate       (i_delay_rate),
        .i_delay_feedback   (i_delay_feedback),
        .i_reverb_wet       (i_reverb_wet),
        .i_reverb_size      (i_reverb_size),
        .i_reverb_feedback  (i_reverb_feedback),
        .i_filter_quality   (i_filter_quality),
        .i_filter_cutoff    (i_filter_cutoff),
        .i_distortion_drive (i_distortion_drive),
        .i_crush_pressure   (i_crush_pressure),
        .i_output_src       (i_output_src),
        .i_crush_src        (i_crush_src),
        .i_distortion_src   (i_distortion_src),
        .i_filter_src       (i_filter_src),
        .i_reverb_src       (i_reverb_src),
        .i_delay_src        (i_delay_src),
        .o_panel            (panel)
    );

    panel_value_mux panel_value_mux_i (
        .clk_dram_ctrl         (clk_dram_ctrl),
        .rst_dram_ctrl         (rst_dram_ctrl),
        .i_panel               (panel),
        .i_disp_sel            (i_disp_sel),
        .i_memrequest_complete (i_memrequest_complete),
        .o_disp_word           (disp_word)
    );

    seven_seg_scan #(
        .hold_cycles (SCAN_HOLD_CYCLES)
    ) seven_seg_scan_i (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_disp_word   (disp_word),
        .o_seg         (o_ss_c),
        .o_anode       (o_ss_an)
    );

    // sticky until reset, marks the first finished write frame
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_write_seen <= 1'b0;
        end else if (i_write_tlast) begin
            o_write_seen <= 1'b1;
        end
    end

endmodule

/* source/seven_seg_scan.sv */
module seven_seg_scan #(
    parameter int hold_cycles = panel_pkg::SCAN_HOLD_CYCLES
) (
    input  logic                              clk_dram_ctrl,
    input  logic                              rst_dram_ctrl,
    input  panel_pkg::disp_word_t             i_disp_word,
    output panel_pkg::seg_t                   o_seg,
    output logic [panel_pkg::DIGIT_COUNT-1:0] o_anode
);
    import panel_pkg::*;

    localparam int HOLD_W      = (hold_cycles > 1) ? $clog2(hold_cycles) : 1;
    localparam int DIGIT_IDX_W = $clog2(DIGIT_COUNT);

    logic [HOLD_W-1:0]      hold_cnt;
    logic [DIGIT_IDX_W-1:0] digit_idx;
    logic                   hold_done;
    nibble_t                cur_nibble;
    logic [DIGIT_COUNT-1:0] cur_anode;

    assign hold_done  = (hold_cnt == HOLD_W'(hold_cycles - 1));
    assign cur_nibble = i_disp_word[digit_idx * NIBBLE_W +: NIBBLE_W];
    assign cur_anode  = ~(DIGIT_COUNT'(1) << digit_idx); // one low bit

    // step to the next digit once the current one has had its time
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            hold_cnt  <= '0;
            digit_idx <= '0;
        end else if (hold_done) begin
            hold_cnt <= '0;
            if (digit_idx == DIGIT_IDX_W'(DIGIT_COUNT - 1)) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // anode and cathode registered together so they switch on the same edge
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_anode <= ANODE_NONE;
            o_seg   <= SEG_BLANK;
        end else begin
            o_anode <= cur_anode;
            o_seg   <= HEX_TO_SEG[cur_nibble];
        end
    end

endmodule

/* source/panel_value_mux.sv */
module panel_value_mux (
    input  logic                  clk_dram_ctrl,
    input  logic                  rst_dram_ctrl,
    panel_if.view_mp              i_panel,
    input  panel_pkg::disp_sel_t  i_disp_sel,
    input  logic                  i_memrequest_complete,
    output panel_pkg::disp_word_t o_disp_word
);
    import panel_pkg::*;

    req_count_t req_count;

    // two settings side by side, each zero-extended to its half
    function automatic disp_word_t pair(input pot_t hi, input pot_t lo);
        return {HALF_W'(hi), HALF_W'(lo)};
    endfunction

    // one count per completed request, wraps
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            req_count <= '0;
        end else if (i_memrequest_complete) begin
            req_count <= req_count + 1'b1;
        end
    end

    always_comb begin
        case (i_disp_sel)
            3'd1: o_disp_word = pair(i_panel.volume, i_panel.pitch);
            3'd2: o_disp_word = pair(i_panel.delay_wet, i_panel.delay_rate);
            3'd3: o_disp_word = pair(i_panel.delay_feedback, i_panel.reverb_wet);
            3'd4: o_disp_word = pair(i_panel.reverb_size, i_panel.reverb_feedback);
            3'd5: o_disp_word = pair(i_panel.filter_quality, i_panel.filter_cutoff);
            3'd6: o_disp_word = pair(i_panel.distortion_drive, i_panel.crush_pressure);
            3'd7: begin
                // one source per digit, top two digits blank
                o_disp_word = {
                    {(DISP_W - SRC_COUNT * NIBBLE_W){1'b0}},
                    NIBBLE_W'(i_panel.delay_src),
                    NIBBLE_W'(i_panel.reverb_src),
                    NIBBLE_W'(i_panel.filter_src),
                    NIBBLE_W'(i_panel.distortion_src),
                    NIBBLE_W'(i_panel.crush_src),
                    NIBBLE_W'(i_panel.output_src)
                };
            end
            default: begin
                o_disp_word = {{HALF_W{1'b0}}, req_count[HALF_W-1:0]}; // low half of count
            end
        endcase
    end

endmodule

/* source/panel_sync.sv */
module panel_sync (
    input  logic              clk_dram_ctrl,
    input  panel_pkg::pot_t   i_volume,
    input  panel_pkg::pot_t   i_pitch,
    input  panel_pkg::pot_t   i_delay_wet,
    input  panel_pkg::pot_t   i_delay_rate,
    input  panel_pkg::pot_t   i_delay_feedback,
    input  panel_pkg::pot_t   i_reverb_wet,
    input  panel_pkg::pot_t   i_reverb_size,
    input  panel_pkg::pot_t   i_reverb_feedback,
    input  panel_pkg::pot_t   i_filter_quality,
    input  panel_pkg::pot_t   i_filter_cutoff,
    input  panel_pkg::pot_t   i_distortion_drive,
    input  panel_pkg::pot_t   i_crush_pressure,
    input  panel_pkg::src_t   i_output_src,
    input  panel_pkg::src_t   i_crush_src,
    input  panel_pkg::src_t   i_distortion_src,
    input  panel_pkg::src_t   i_filter_src,
    input  panel_pkg::src_t   i_reverb_src,
    input  panel_pkg::src_t   i_delay_src,
    panel_if.sync_mp          o_panel
);
    import panel_pkg::*;

    pot_t [POT_COUNT-1:0] pot_in;
    src_t [SRC_COUNT-1:0] src_in;
    pot_t [POT_COUNT-1:0] pot_chain [SYNC_STAGES];
    src_t [SRC_COUNT-1:0] src_chain [SYNC_STAGES];

    // index 0 at the right
    assign pot_in = {i_crush_pressure, i_distortion_drive, i_filter_cutoff, i_filter_quality,
                     i_reverb_feedback, i_reverb_size, i_reverb_wet, i_delay_feedback,
                     i_delay_rate, i_delay_wet, i_pitch, i_volume};
    assign src_in = {i_delay_src, i_reverb_src, i_filter_src,
                     i_distortion_src, i_crush_src, i_output_src};

    // each value walks the chain into the controller domain
    always_ff @(posedge clk_dram_ctrl) begin
        pot_chain[0] <= pot_in;
        src_chain[0] <= src_in;
        for (int s = 1; s < SYNC_STAGES; s++) begin
            pot_chain[s] <= pot_chain[s-1];
            src_chain[s] <= src_chain[s-1];
        end
    end

    assign o_panel.volume           = pot_chain[SYNC_STAGES-1][0];
    assign o_panel.pitch            = pot_chain[SYNC_STAGES-1][1];
    assign o_panel.delay_wet        = pot_chain[SYNC_STAGES-1][2];
    assign o_panel.delay_rate       = pot_chain[SYNC_STAGES-1][3];
    assign o_panel.delay_feedback   = pot_chain[SYNC_STAGES-1][4];
    assign o_panel.reverb_wet       = pot_chain[SYNC_STAGES-1][5];
    assign o_panel.reverb_size      = pot_chain[SYNC_STAGES-1][6];
    assign o_panel.reverb_feedback  = pot_chain[SYNC_STAGES-1][7];
    assign o_panel.filter_quality   = pot_chain[SYNC_STAGES-1][8];
    assign o_panel.filter_cutoff    = pot_chain[SYNC_STAGES-1][9];
    assign o_panel.distortion_drive = pot_chain[SYNC_STAGES-1][10];
    assign o_panel.crush_pressure   = pot_chain[SYNC_STAGES-1][11];

    assign o_panel.output_src     = src_chain[SYNC_STAGES-1][0];
    assign o_panel.crush_src      = src_chain[SYNC_STAGES-1][1];
    assign o_panel.distortion_src = src_chain[SYNC_STAGES-1][2];
    assign o_panel.filter_src     = src_chain[SYNC_STAGES-1][3];
    assign o_panel.reverb_src     = src_chain[SYNC_STAGES-1][4];
    assign o_panel.delay_src      = src_chain[SYNC_STAGES-1][5];

endmodule

/* source/panel_if.sv */
interface panel_if;
    import panel_pkg::*;

    // knob settings, already in the controller domain
    pot_t volume, pitch;
    pot_t delay_wet, delay_rate, delay_feedback;
    pot_t reverb_wet, reverb_size, reverb_feedback;
    pot_t filter_quality, filter_cutoff;
    pot_t distortion_drive, crush_pressure;

    // patch sources
    src_t output_src, crush_src, distortion_src;
    src_t filter_src, reverb_src, delay_src;

    modport sync_mp (
        output volume, pitch, delay_wet, delay_rate, delay_feedback,
        output reverb_wet, reverb_size, reverb_feedback,
        output filter_quality, filter_cutoff, distortion_drive, crush_pressure,
        output output_src, crush_src, distortion_src, filter_src, reverb_src, delay_src
    );

    modport view_mp (
        input volume, pitch, delay_wet, delay_rate, delay_feedback,
        input reverb_wet, reverb_size, reverb_feedback,
        input filter_quality, filter_cutoff, distortion_drive, crush_pressure,
        input output_src, crush_src, distortion_src, filter_src, reverb_src, delay_src
    );

endinterface

/* source/panel_pkg.sv */
package panel_pkg;

    // field widths
    localparam int POT_W       = 10;
    localparam int SRC_W       = 3;
    localparam int DISP_SEL_W  = 3;
    localparam int NIBBLE_W    = 4;
    localparam int SEG_W       = 7;
    localparam int REQ_COUNT_W = 24;

    localparam int DIGIT_COUNT = 8;
    localparam int DISP_W      = DIGIT_COUNT * NIBBLE_W;
    localparam int HALF_W      = DISP_W / 2; // one setting per half

    localparam int POT_COUNT   = 12; // knob settings on the panel
    localparam int SRC_COUNT   = 6;  // patch-source selections

    localparam int SYNC_STAGES      = 2;
    localparam int SCAN_HOLD_CYCLES = 4; // thousands on a real board

    typedef logic [POT_W-1:0]       pot_t;
    typedef logic [SRC_W-1:0]       src_t;
    typedef logic [DISP_SEL_W-1:0]  disp_sel_t;
    typedef logic [DISP_W-1:0]      disp_word_t;
    typedef logic [NIBBLE_W-1:0]    nibble_t;
    typedef logic [SEG_W-1:0]       seg_t;       // a in bit 0 .. g in bit 6
    typedef logic [REQ_COUNT_W-1:0] req_count_t;

    // display is active low on both anodes and cathodes
    localparam seg_t SEG_BLANK = '1;
    localparam logic [DIGIT_COUNT-1:0] ANODE_NONE = '1;

    // hex digit to cathode pattern, lit segment = 0
    localparam seg_t HEX_TO_SEG [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, // 0 1 2 3
        7'h19, 7'h12, 7'h02, 7'h78, // 4 5 6 7
        7'h00, 7'h10, 7'h08, 7'h03, // 8 9 A b
        7'h46, 7'h21, 7'h06, 7'h0E  // C d E F
    };

endpackage
